/* rtl/vdc_pkg.sv */
// ########################################
// video/audio display controller package
// register map, configuration structs and
// host bus encodings shared by the core
// ########################################

package vdc_pkg;

    // 4-bit register number on the host bus
    typedef logic [3:0] reg_num_t;

    // register map (16-bit registers)
    localparam reg_num_t REG_CTRL       = 4'd0;     // bit 0 video enable
    localparam reg_num_t REG_BORDER     = 4'd1;     // 12-bit rgb colour
    localparam reg_num_t REG_STATUS     = 4'd2;     // read only, vblank + frame count
    localparam reg_num_t REG_VOICE_BASE = 4'd4;     // period/volume pairs from here

    // host bus encodings
    localparam logic CS_ENABLED = 1'b0;             // chip select is active low
    localparam logic RNW_READ   = 1'b1;             // rd_nwr high for a read
    localparam logic BYTE_EVEN  = 1'b0;             // even byte is bits 15:8

    // 12-bit colour, 4 bits per channel
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // one tone voice setup
    typedef struct packed {
        logic [15:0] period;                        // 0 holds the voice high
        logic [7:0]  volume;
    } voice_cfg_t;

    // video control from the register block
    typedef struct packed {
        logic enable;                               // colour output on/off
        rgb_t border;
    } vid_ctrl_t;

endpackage

/* rtl/vdc_tone_voice.sv */
// ########################################
// square-wave tone voice
// level toggles between volume and zero
// every period+1 clocks
// ########################################

`timescale 1ns/1ps

module vdc_tone_voice (
    input  logic                pclk,
    input  logic                rst_i,
    input  vdc_pkg::voice_cfg_t cfg_i,
    output logic [7:0]          level_o
);

    logic [15:0] period_cnt;                    // clocks left in this half wave
    logic        phase;                         // high half of the square wave

    always_ff @(posedge pclk or posedge rst_i) begin
        if (rst_i) begin
            period_cnt <= '0;
            phase      <= 1'b0;
        end else if (cfg_i.period == 16'd0) begin
            period_cnt <= '0;                   // stopped voice sits at its high level
            phase      <= 1'b1;
        end else if (period_cnt == 16'd0) begin
            period_cnt <= cfg_i.period;         // reload, counts period..0
            phase      <= ~phase;
        end else begin
            period_cnt <= period_cnt - 1'b1;
        end
    end

    assign level_o = phase ? cfg_i.volume : 8'h00;  // volume gate

endmodule

/* rtl/vdc_audio_mixer.sv */
// ########################################
// audio mixer
// even voices to left, odd to right, each
// side turned into a 1-bit pulse density
// stream by a first-order accumulator
// ########################################

`timescale 1ns/1ps

module vdc_audio_mixer #(
    parameter int NUM_VOICES = 4
) (
    input  logic                       pclk,
    input  logic                       rst_i,
    input  logic [NUM_VOICES-1:0][7:0] level_i,
    output logic                       audio_l_o,
    output logic                       audio_r_o
);

    localparam int HALF  = NUM_VOICES / 2;      // voices per side
    localparam int ACC_W = 8 + $clog2(HALF);    // wide enough for the full side sum

    logic [1:0] pdm_bit;                        // 0 left, 1 right

    for (genvar s = 0; s < 2; s++) begin : g_side
        logic [ACC_W-1:0] side_sum;
        logic [ACC_W-1:0] acc;
        logic [ACC_W:0]   acc_next;             // top bit is the density carry
        logic             pdm_q;

        // voices 2k+s belong to this side
        always_comb begin
            side_sum = '0;
            for (int k = 0; k < HALF; k++) begin
                side_sum = side_sum + ACC_W'(level_i[2 * k + s]);
            end
        end

        assign acc_next = {1'b0, acc} + {1'b0, side_sum};

        always_ff @(posedge pclk or posedge rst_i) begin
            if (rst_i) begin
                acc   <= '0;
                pdm_q <= 1'b0;
            end else begin
                acc   <= acc_next[ACC_W-1:0];
                pdm_q <= acc_next[ACC_W];       // one carry per 2^ACC_W of sum
            end
        end

        assign pdm_bit[s] = pdm_q;
    end

    assign audio_l_o = pdm_bit[0];
    assign audio_r_o = pdm_bit[1];

endmodule

/* rtl/vdc_video_timing.sv */
// ########################################
// video timing generator
// h/v counters, active-high syncs, display
// enable, registered colour and a frame
// counter that steps at vertical blank
// ########################################

`timescale 1ns/1ps

module vdc_video_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic               pclk,
    input  logic               rst_i,
    input  vdc_pkg::vid_ctrl_t vid_ctrl_i,
    output vdc_pkg::rgb_t      rgb_o,
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o,
    output logic               vblank_o,
    output logic [7:0]         frame_count_o
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HW      = $clog2(H_TOTAL);
    localparam int VW      = $clog2(V_TOTAL);

    logic [HW-1:0] h_count;                     // pixel within line
    logic [VW-1:0] v_count;                     // line within frame
    logic          h_last;
    logic          v_last;
    logic          h_active;
    logic          v_active;
    logic          h_sync;
    logic          v_sync;

    // line order is active, front porch, sync, back porch
    assign h_last   = h_count == HW'(H_TOTAL - 1);
    assign v_last   = v_count == VW'(V_TOTAL - 1);
    assign h_active = h_count < HW'(H_ACTIVE);
    assign v_active = v_count < VW'(V_ACTIVE);
    assign h_sync   = (h_count >= HW'(H_ACTIVE + H_FRONT))
                      && (h_count < HW'(H_ACTIVE + H_FRONT + H_SYNC));
    assign v_sync   = (v_count >= VW'(V_ACTIVE + V_FRONT))
                      && (v_count < VW'(V_ACTIVE + V_FRONT + V_SYNC));

    always_ff @(posedge pclk or posedge rst_i) begin
        if (rst_i) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_last) begin
            h_count <= '0;
            v_count <= v_last ? '0 : v_count + 1'b1;   // wrap at end of frame
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // all outputs registered together so they stay aligned
    always_ff @(posedge pclk or posedge rst_i) begin
        if (rst_i) begin
            hsync_o       <= 1'b0;
            vsync_o       <= 1'b0;
            de_o          <= 1'b0;
            vblank_o      <= 1'b0;
            rgb_o         <= '0;
            frame_count_o <= '0;
        end else begin
            hsync_o  <= h_sync;
            vsync_o  <= v_sync;
            de_o     <= h_active && v_active;
            vblank_o <= !v_active;
            // border colour only inside the active area and when enabled
            rgb_o    <= (vid_ctrl_i.enable && h_active && v_active) ? vid_ctrl_i.border : '0;
            if (h_last && (v_count == VW'(V_ACTIVE - 1))) begin
                frame_count_o <= frame_count_o + 1'b1;  // last active line done
            end
        end
    end

endmodule

/* rtl/vdc_bus_regs.sv */
// ########################################
// host register block
// synchronises the byte-wide host bus, does
// byte-lane writes on the select edge and
// muxes read data, STATUS from live timing
// ########################################

`timescale 1ns/1ps

module vdc_bus_regs #(
    parameter int NUM_VOICES = 4
) (
    input  logic                                 pclk,
    input  logic                                 rst_i,
    input  logic                                 bus_cs_n_i,
    input  logic                                 bus_rd_nwr_i,
    input  logic                                 bus_bytesel_i,
    input  vdc_pkg::reg_num_t                    bus_reg_num_i,
    input  logic [7:0]                           bus_data_i,
    input  logic                                 vblank_i,
    input  logic [7:0]                           frame_count_i,
    output logic [7:0]                           bus_data_o,
    output vdc_pkg::vid_ctrl_t                   vid_ctrl_o,
    output vdc_pkg::voice_cfg_t [NUM_VOICES-1:0] voice_cfg_o
);
    import vdc_pkg::*;

    // one sample of the host bus
    typedef struct packed {
        logic       cs_n;
        logic       rd_nwr;
        logic       bytesel;
        reg_num_t   reg_num;
        logic [7:0] data;
    } bus_sample_t;

    bus_sample_t bus_raw;
    bus_sample_t bus_meta;                      // first sync stage
    bus_sample_t bus_sync;                      // second sync stage, safe to use
    logic        cs_n_last;                     // previous synced select
    logic        wr_stb;                        // write on the next clock
    logic [15:0] reg_words [16];                // readable view of every register
    logic [15:0] rd_word;
    logic [15:0] wr_word;

    // register number of voice idx, odd selects the volume half of the pair
    function automatic reg_num_t voice_reg(input int idx, input logic odd);
        return reg_num_t'(REG_VOICE_BASE + 2 * idx + int'(odd));
    endfunction

    // replace one byte lane of a 16-bit word
    function automatic logic [15:0] merge_byte(input logic [15:0] old_word,
                                               input logic sel, input logic [7:0] data);
        return (sel == BYTE_EVEN) ? {data, old_word[7:0]} : {old_word[15:8], data};
    endfunction

    assign bus_raw = '{cs_n: bus_cs_n_i, rd_nwr: bus_rd_nwr_i, bytesel: bus_bytesel_i,
                       reg_num: bus_reg_num_i, data: bus_data_i};

    // two-flop synchroniser, runs during reset as well
    always_ff @(posedge pclk) begin
        bus_meta <= bus_raw;
        bus_sync <= bus_meta;
    end

    // falling select with a write, seen after the sync stages
    always_ff @(posedge pclk or posedge rst_i) begin
        if (rst_i) begin
            cs_n_last <= CS_ENABLED;            // a cycle already open at release is skipped
            wr_stb    <= 1'b0;
        end else begin
            cs_n_last <= bus_sync.cs_n;
            wr_stb    <= (cs_n_last != CS_ENABLED) && (bus_sync.cs_n == CS_ENABLED)
                         && (bus_sync.rd_nwr != RNW_READ);
        end
    end

    // every register as a 16-bit word, unused numbers read zero
    always_comb begin
        reg_words               = '{default: '0};
        reg_words[REG_CTRL]     = {15'b0, vid_ctrl_o.enable};
        reg_words[REG_BORDER]   = {4'b0, vid_ctrl_o.border};
        reg_words[REG_STATUS]   = {frame_count_i, 7'b0, vblank_i};
        for (int i = 0; i < NUM_VOICES; i++) begin
            reg_words[voice_reg(i, 1'b0)] = voice_cfg_o[i].period;
            reg_words[voice_reg(i, 1'b1)] = {8'h00, voice_cfg_o[i].volume};
        end
    end

    // read straight from the raw pins, no sync delay
    assign rd_word    = reg_words[bus_reg_num_i];
    assign bus_data_o = (bus_bytesel_i == BYTE_EVEN) ? rd_word[15:8] : rd_word[7:0];

    // new value of the addressed register with the written byte merged in
    assign wr_word = merge_byte(reg_words[bus_sync.reg_num], bus_sync.bytesel, bus_sync.data);

    always_ff @(posedge pclk or posedge rst_i) begin
        if (rst_i) begin
            vid_ctrl_o  <= '0;
            voice_cfg_o <= '0;                  // period 0, volume 0 -> silent
        end else if (wr_stb) begin
            case (bus_sync.reg_num)
                REG_CTRL:   vid_ctrl_o.enable <= wr_word[0];
                REG_BORDER: vid_ctrl_o.border <= wr_word[11:0];
                default: begin                  // STATUS and spare numbers match nothing here
                    for (int i = 0; i < NUM_VOICES; i++) begin
                        if (bus_sync.reg_num == voice_reg(i, 1'b0)) begin
                            voice_cfg_o[i].period <= wr_word;
                        end
                        if (bus_sync.reg_num == voice_reg(i, 1'b1)) begin
                            voice_cfg_o[i].volume <= wr_word[7:0];  // high byte dropped
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* rtl/vdc_board_top.sv */
// ########################################
// video/audio display controller, board top
// splits the tri-state host data bus, holds
// the core in reset for RESET_DELAY clocks,
// and wires the register block, video
// timing, tone voices and audio mixer
// ########################################

`timescale 1ns/1ps

module vdc_board_top #(
    parameter int NUM_VOICES  = 4,          // tone voices, even count
    parameter int H_ACTIVE    = 640,
    parameter int H_FRONT     = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BACK      = 48,
    parameter int V_ACTIVE    = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33,
    parameter int RESET_DELAY = 255         // core reset length after arst_n_i
) (
    input  logic              pclk,         // pixel clock
    input  logic              arst_n_i,     // external reset
    input  logic              bus_cs_n_i,   // host select, active low
    input  logic              bus_rd_nwr_i, // read high, write low
    input  logic              bus_bytesel_i,// even/odd byte
    input  vdc_pkg::reg_num_t bus_reg_num_i,
    inout  wire  [7:0]        bus_data_io,  // bidirectional host data
    output logic [3:0]        vga_r_o,
    output logic [3:0]        vga_g_o,
    output logic [3:0]        vga_b_o,
    output logic              vga_hs_o,
    output logic              vga_vs_o,
    output logic              dv_de_o,      // display enable
    output logic              audio_l_o,    // pulse density left
    output logic              audio_r_o     // pulse density right
);
    import vdc_pkg::*;

    localparam int RST_W = $clog2(RESET_DELAY + 1);

    // tri-state split
    logic       bus_out_ena;
    logic [7:0] bus_data_in;
    logic [7:0] bus_data_out;

    // core reset delay
    logic [RST_W-1:0] rst_cnt;
    logic             core_rst;

    // internal buses between blocks
    vid_ctrl_t                    vid_ctrl;
    voice_cfg_t [NUM_VOICES-1:0]  voice_cfg;
    logic [NUM_VOICES-1:0][7:0]   voice_level;
    rgb_t                         vid_rgb;
    logic                         vblank;
    logic [7:0]                   frame_count;

    // drive the data pins only for a selected read cycle
    assign bus_out_ena = (bus_cs_n_i == CS_ENABLED) && (bus_rd_nwr_i == RNW_READ);
    assign bus_data_io = bus_out_ena ? bus_data_out : 8'bz;
    assign bus_data_in = bus_data_io;

    // colour struct out to the pins
    assign vga_r_o = vid_rgb.red;
    assign vga_g_o = vid_rgb.green;
    assign vga_b_o = vid_rgb.blue;

    // count RESET_DELAY clocks after release, then let the core run
    always_ff @(posedge pclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rst_cnt  <= '0;
            core_rst <= 1'b1;
        end else if (core_rst) begin
            if (rst_cnt == RST_W'(RESET_DELAY - 1)) begin
                core_rst <= 1'b0;                   // last delay clock
            end else begin
                rst_cnt  <= rst_cnt + 1'b1;
            end
        end
    end

    vdc_bus_regs #(
        .NUM_VOICES     (NUM_VOICES)
    ) u_bus_regs (
        .pclk           (pclk),
        .rst_i          (core_rst),
        .bus_cs_n_i     (bus_cs_n_i),
        .bus_rd_nwr_i   (bus_rd_nwr_i),
        .bus_bytesel_i  (bus_bytesel_i),
        .bus_reg_num_i  (bus_reg_num_i),
        .bus_data_i     (bus_data_in),
        .vblank_i       (vblank),
        .frame_count_i  (frame_count),
        .bus_data_o     (bus_data_out),
        .vid_ctrl_o     (vid_ctrl),
        .voice_cfg_o    (voice_cfg)
    );

    vdc_video_timing #(
        .H_ACTIVE       (H_ACTIVE),
        .H_FRONT        (H_FRONT),
        .H_SYNC         (H_SYNC),
        .H_BACK         (H_BACK),
        .V_ACTIVE       (V_ACTIVE),
        .V_FRONT        (V_FRONT),
        .V_SYNC         (V_SYNC),
        .V_BACK         (V_BACK)
    ) u_video_timing (
        .pclk           (pclk),
        .rst_i          (core_rst),
        .vid_ctrl_i     (vid_ctrl),
        .rgb_o          (vid_rgb),
        .hsync_o        (vga_hs_o),
        .vsync_o        (vga_vs_o),
        .de_o           (dv_de_o),
        .vblank_o       (vblank),
        .frame_count_o  (frame_count)
    );

    // one square-wave voice per register pair
    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_voice
        vdc_tone_voice u_voice (
            .pclk       (pclk),
            .rst_i      (core_rst),
            .cfg_i      (voice_cfg[i]),
            .level_o    (voice_level[i])
        );
    end

    vdc_audio_mixer #(
        .NUM_VOICES     (NUM_VOICES)
    ) u_audio_mixer (
        .pclk           (pclk),
        .rst_i          (core_rst),
        .level_i        (voice_level),
        .audio_l_o      (audio_l_o),
        .audio_r_o      (audio_r_o)
    );

endmodule

/* test/tb_vdc_checks.svh */
// ########################################
// display controller checks
// measurement helpers, assertions and the
// test sequences built on them
// ########################################

localparam int SIG_HS = 0;
localparam int SIG_VS = 1;
localparam int SIG_DE = 2;

function automatic logic timing_bit(input int sel);
    case (sel)
        SIG_HS:  return vga_hs;
        SIG_VS:  return vga_vs;
        default: return dv_de;
    endcase
endfunction

task automatic check_eq(input string name, input int got, input int exp);
    check_count++;
    assert (got == exp) else begin
        $display("FAIL %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        error_count++;
    end
endtask

task automatic check_near(input string name, input int got, input int exp, input int tol);
    check_count++;
    assert ((got >= exp - tol) && (got <= exp + tol)) else begin
        $display("FAIL %0t %s got %0d expected %0d +/-%0d", $time, name, got, exp, tol);
        error_count++;
    end
endtask

task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond) else begin
        $display("ERROR %0t %s", $time, what);
        error_count++;
    end
endtask

task automatic report_timeout(input string what);
    error_count++;
    $display("ERROR %0t timed out waiting for %s", $time, what);
endtask

// step until the bit has the level, counting cycles
task automatic wait_level(input int sel, input logic val, output int cycles);
    cycles = 0;
    while ((timing_bit(sel) !== val) && (cycles < WAIT_LIMIT)) begin
        @(negedge pclk);
        cycles++;
    end
    if (timing_bit(sel) !== val) begin
        report_timeout($sformatf("timing signal %0d", sel));
    end
endtask

task automatic wait_rise(input int sel);
    int c;
    wait_level(sel, 1'b0, c);
    wait_level(sel, 1'b1, c);
endtask

// cycles from one rising edge to the next
task automatic measure_period(input int sel, output int period);
    int low_c;
    int high_c;
    wait_rise(sel);
    wait_level(sel, 1'b0, high_c);
    wait_level(sel, 1'b1, low_c);
    period = high_c + low_c;
endtask

task automatic count_audio(input int cycles, output int ones_l, output int ones_r);
    ones_l = 0;
    ones_r = 0;
    repeat (cycles) begin
        @(negedge pclk);
        ones_l += int'(audio_l);
        ones_r += int'(audio_r);
    end
endtask

task automatic check_outputs_low();
    check_eq("vga_rgb", {vga_r, vga_g, vga_b}, 0);
    check_eq("vga_hs", vga_hs, 0);
    check_eq("vga_vs", vga_vs, 0);
    check_eq("dv_de", dv_de, 0);
    check_eq("audio", {audio_l, audio_r}, 0);
endtask

// outputs quiet for the whole delay, and a write in it is dropped
task automatic run_reset_test();
    logic [15:0] v;
    begin_test();
    fork
        repeat (RESET_DELAY) begin
            @(negedge pclk);
            check_outputs_low();
        end
        bus_write(REG_CTRL, ~BYTE_EVEN, 8'h01);
    join
    read_reg16(REG_CTRL, v);
    check_eq("ctrl", v, 0);
    end_test("reset");
endtask

task automatic run_register_test();
    logic [15:0] v;
    logic [15:0] mask [16];
    reg_num_t    num;
    begin_test();
    for (int i = 0; i < 16; i++) begin
        mask[i] = 16'h0000;
    end
    mask[REG_CTRL]   = 16'h0001;                // enable bit only
    mask[REG_BORDER] = 16'h0fff;
    for (int i = 0; i < NUM_VOICES; i++) begin
        mask[REG_VOICE_BASE + 2 * i]     = 16'hffff;
        mask[REG_VOICE_BASE + 2 * i + 1] = 16'h00ff;  // volume in the low byte
    end
    for (int i = 0; i < 16; i++) begin
        if (mask[i] != 16'h0000) begin
            num = reg_num_t'(i);
            v = 16'($urandom);
            write_reg16(num, v);
            shadow[i] = v & mask[i];
        end
    end
    for (int i = 0; i < 16; i++) begin
        if (mask[i] != 16'h0000) begin
            read_reg16(reg_num_t'(i), v);
            check_eq($sformatf("reg%0d", i), v, shadow[i]);
        end
    end
    read_reg16(REG_STATUS, v);
    check_eq("status[7:1]", v[7:1], 0);
    write_reg16(reg_num_t'(3), 16'($urandom));  // spare numbers keep nothing
    write_reg16(reg_num_t'(15), 16'($urandom));
    read_reg16(reg_num_t'(3), v);
    check_eq("reg3", v, 0);
    read_reg16(reg_num_t'(15), v);
    check_eq("reg15", v, 0);
    end_test("registers");
endtask

task automatic run_timing_test();
    int          n;
    logic [15:0] s0;
    logic [15:0] s1;
    begin_test();
    repeat (3) begin
        measure_period(SIG_HS, n);
        check_eq("hsync period", n, H_TOTAL);
    end
    repeat (3) begin
        wait_rise(SIG_DE);
        wait_level(SIG_DE, 1'b0, n);            // high run length of one line
        check_eq("de per line", n, H_ACTIVE);
    end
    repeat (2) begin
        measure_period(SIG_VS, n);
        check_eq("vsync period", n, H_TOTAL * V_TOTAL);
    end
    repeat (2) begin
        wait_rise(SIG_VS);
        read_reg16(REG_STATUS, s0);
        wait_rise(SIG_VS);
        read_reg16(REG_STATUS, s1);
        check_eq("frame count", s1[15:8], 8'(s0[15:8] + 8'd1));
    end
    end_test("timing");
endtask

// one whole frame, so the enable region covers every active pixel once
task automatic scan_colour(input logic [11:0] border, input logic enable);
    logic [11:0] exp;
    int          de_cycles;
    de_cycles = 0;
    repeat (H_TOTAL * V_TOTAL) begin
        @(negedge pclk);
        exp = (enable && dv_de) ? border : 12'h000;
        check_eq("vga_rgb", {vga_r, vga_g, vga_b}, exp);
        de_cycles += int'(dv_de);
    end
    check_eq("de per frame", de_cycles, H_ACTIVE * V_ACTIVE);
endtask

task automatic run_colour_test();
    logic [11:0] border;
    begin_test();
    border = 12'($urandom);
    write_reg16(REG_BORDER, {4'h0, border});
    write_reg16(REG_CTRL, 16'h0001);
    scan_colour(border, 1'b1);
    write_reg16(REG_CTRL, 16'h0000);
    scan_colour(border, 1'b0);
    end_test("colour");
endtask

task automatic run_audio_level_test();
    int         sum_l;
    int         sum_r;
    int         ones_l;
    int         ones_r;
    logic [7:0] vol;
    begin_test();
    sum_l = 0;
    sum_r = 0;
    for (int i = 0; i < NUM_VOICES; i++) begin
        vol = 8'($urandom);
        write_reg16(reg_num_t'(REG_VOICE_BASE + 2 * i), 16'h0000);  // held high
        write_reg16(reg_num_t'(REG_VOICE_BASE + 2 * i + 1), {8'h00, vol});
        if (i % 2 == 0) begin
            sum_l += vol;
        end else begin
            sum_r += vol;
        end
    end
    repeat (4) @(negedge pclk);
    count_audio(512, ones_l, ones_r);
    check_near("audio_l ones", ones_l, sum_l, 1);
    check_near("audio_r ones", ones_r, sum_r, 1);
    for (int i = 0; i < NUM_VOICES; i++) begin
        write_reg16(reg_num_t'(REG_VOICE_BASE + 2 * i + 1), 16'h0000);
    end
    repeat (4) @(negedge pclk);
    count_audio(512, ones_l, ones_r);
    check_eq("audio_l ones", ones_l, 0);
    check_eq("audio_r ones", ones_r, 0);
    end_test("audio level");
endtask

// voice 0 toggles, so adjacent windows of P+1 cycles differ in density
task automatic run_tone_test();
    int p;
    int full;
    int best;
    int a_l;
    int a_r;
    int b_l;
    int b_r;
    begin_test();
    p = 32 + int'($urandom % 32);
    full = (p + 1) * 255 / 512;                 // ones in a window with the level high
    best = 0;
    write_reg16(reg_num_t'(REG_VOICE_BASE + 1), 16'h00ff);
    write_reg16(REG_VOICE_BASE, 16'(p));
    for (int off = 0; off < 2; off++) begin
        repeat (off * (p + 1) / 2) @(negedge pclk);  // second try half a window later
        count_audio(p + 1, a_l, a_r);
        count_audio(p + 1, b_l, b_r);
        if (a_l - b_l > best) best = a_l - b_l;
        if (b_l - a_l > best) best = b_l - a_l;
        check_eq("audio_r ones", a_r + b_r, 0);
    end
    check_true(best * 4 >= full, $sformatf("left density did not follow tone, diff %0d", best));
    end_test("tone");
endtask

/* test/tb_vdc_board.sv */
// ########################################
// testbench for the display controller
// clock, reset, host bus tasks and the
// stimulus for each test, with a summary
// ########################################

`timescale 1ns/1ps

module tb_vdc_board;
    import vdc_pkg::*;

    localparam int H_ACTIVE    = 16;
    localparam int H_FRONT     = 2;
    localparam int H_SYNC      = 4;
    localparam int H_BACK      = 2;
    localparam int V_ACTIVE    = 8;
    localparam int V_FRONT     = 1;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 1;
    localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int NUM_VOICES  = 4;
    localparam int RESET_DELAY = 16;
    localparam int CLK_PERIOD  = 40;
    localparam int WAIT_LIMIT  = 4 * H_TOTAL * V_TOTAL;   // cycles before a wait gives up

    logic       pclk;
    logic       arst_n_i;
    logic       bus_cs_n;
    logic       bus_rd_nwr;
    logic       bus_bytesel;
    reg_num_t   bus_reg_num;
    logic       host_drive;                     // testbench owns the data bus
    logic [7:0] host_data;
    wire  [7:0] bus_data;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       vga_hs;
    logic       vga_vs;
    logic       dv_de;
    logic       audio_l;
    logic       audio_r;

    int          error_count;
    int          check_count;
    int          test_count;
    int          test_fail_count;
    int          test_err_start;                // error count when the test began
    logic [15:0] shadow [16];                   // expected register contents

    assign bus_data = host_drive ? host_data : 8'bz;

    vdc_board_top #(
        .NUM_VOICES  (NUM_VOICES),
        .H_ACTIVE    (H_ACTIVE),
        .H_FRONT     (H_FRONT),
        .H_SYNC      (H_SYNC),
        .H_BACK      (H_BACK),
        .V_ACTIVE    (V_ACTIVE),
        .V_FRONT     (V_FRONT),
        .V_SYNC      (V_SYNC),
        .V_BACK      (V_BACK),
        .RESET_DELAY (RESET_DELAY)
    ) uut (
        .pclk          (pclk),
        .arst_n_i      (arst_n_i),
        .bus_cs_n_i    (bus_cs_n),
        .bus_rd_nwr_i  (bus_rd_nwr),
        .bus_bytesel_i (bus_bytesel),
        .bus_reg_num_i (bus_reg_num),
        .bus_data_io   (bus_data),
        .vga_r_o       (vga_r),
        .vga_g_o       (vga_g),
        .vga_b_o       (vga_b),
        .vga_hs_o      (vga_hs),
        .vga_vs_o      (vga_vs),
        .dv_de_o       (dv_de),
        .audio_l_o     (audio_l),
        .audio_r_o     (audio_r)
    );

    initial begin
        pclk = 1'b0;
        forever #(CLK_PERIOD / 2) pclk = ~pclk;
    end

    `include "tb_vdc_checks.svh"

    // one byte write, held well past the sync delay
    task automatic bus_write(input reg_num_t num, input logic sel, input logic [7:0] data);
        @(negedge pclk);
        bus_cs_n    = CS_ENABLED;
        bus_rd_nwr  = ~RNW_READ;
        bus_bytesel = sel;
        bus_reg_num = num;
        host_data   = data;
        host_drive  = 1'b1;
        repeat (6) @(negedge pclk);
        bus_cs_n   = ~CS_ENABLED;
        bus_rd_nwr = RNW_READ;
        host_drive = 1'b0;
        repeat (4) @(negedge pclk);             // idle so the next select edge is seen
    endtask

    task automatic bus_read(input reg_num_t num, input logic sel, output logic [7:0] data);
        @(negedge pclk);
        bus_cs_n    = CS_ENABLED;
        bus_rd_nwr  = RNW_READ;
        bus_bytesel = sel;
        bus_reg_num = num;
        @(negedge pclk);
        data     = bus_data;                    // one cycle after the inputs settle
        bus_cs_n = ~CS_ENABLED;
        repeat (2) @(negedge pclk);
    endtask

    task automatic write_reg16(input reg_num_t num, input logic [15:0] value);
        bus_write(num, BYTE_EVEN, value[15:8]);
        bus_write(num, ~BYTE_EVEN, value[7:0]);
    endtask

    task automatic read_reg16(input reg_num_t num, output logic [15:0] value);
        logic [7:0] hi;
        logic [7:0] lo;
        bus_read(num, BYTE_EVEN, hi);
        bus_read(num, ~BYTE_EVEN, lo);
        value = {hi, lo};
    endtask

    task automatic begin_test();
        test_count++;
        test_err_start = error_count;
    endtask

    task automatic end_test(input string name);
        if (error_count != test_err_start) begin
            test_fail_count++;
            $display("test %0d %s: failed", test_count, name);
        end else begin
            $display("test %0d %s: passed", test_count, name);
        end
    endtask

    task automatic finish_run();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, test_fail_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'hbcc3_0a86));         // single seed for the whole run
        error_count     = 0;
        check_count     = 0;
        test_count      = 0;
        test_fail_count = 0;
        test_err_start  = 0;
        arst_n_i    = 1'b0;
        bus_cs_n    = ~CS_ENABLED;
        bus_rd_nwr  = RNW_READ;
        bus_bytesel = BYTE_EVEN;
        bus_reg_num = '0;
        host_drive  = 1'b0;
        host_data   = '0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = '0;
        end
        repeat (8) @(negedge pclk);
        arst_n_i = 1'b1;
        run_reset_test();
        run_register_test();
        run_timing_test();
        run_colour_test();
        run_audio_level_test();
        run_tone_test();
        finish_run();
    end

endmodule

/* verilog.f */
+incdir+test
rtl/vdc_pkg.sv
rtl/vdc_tone_voice.sv
rtl/vdc_audio_mixer.sv
rtl/vdc_video_timing.sv
rtl/vdc_bus_regs.sv
rtl/vdc_board_top.sv
test/tb_vdc_board.sv

/* run_sim.sh */
#!/bin/sh
# build and run the display controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vdc_board -f verilog.f -o vdc_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/vdc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
